/* run_sim.sh */
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator and runs it.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -f sources.f --top-module idli_ex_tb -o idli_ex_sim \
  > build.log 2>&1 \
  && ./obj_dir/idli_ex_sim > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "^Simulation PASSED$" sim.log \
  && echo "PASS: see sim.log" \
  || { echo "FAIL: see sim.log"; exit 1; }

/* sources.f */
+incdir+src
src/idli_ex_pkg.sv
src/idli_ex_ctrl.sv
src/idli_ex_rf.sv
src/idli_ex_alu.sv
src/idli_ex_top.sv
tests/idli_ex_tb.sv

/* src/idli_ex_alu.sv */
`timescale 1ns/10ps
`include "idli_ex_cfg.svh"

// Slice ALU. Carry and the zero accumulator are kept between slices so that
// four passes give a full 16-bit result and flags for the whole word.
module idli_ex_alu (
  // Clock.
  input  var logic                  i_ex_gck,

  // Operation and slice position.
  input  var idli_ex_pkg::alu_ctl_t i_ex_ctl,

  // Operand slices and the immediate slice.
  input  var idli_ex_pkg::slice_t   i_ex_lhs,
  input  var idli_ex_pkg::slice_t   i_ex_rhs,
  input  var idli_ex_pkg::slice_t   i_ex_imm,

  // Result slice and whole-word flags.
  output var idli_ex_pkg::slice_t   o_ex_out,
  output var idli_ex_pkg::flags_t   o_ex_flags
);

  // Carry and zero state from the previous slice.
  logic                    carry_q;
  logic                    zero_q;

  // Adder inputs and outputs.
  logic                    cin;
  idli_ex_pkg::slice_t     rhs_eff;
  logic [`IDLI_SLICE_W:0]  sum;
  logic                    cout;

  // Whether every result slice so far, this one included, was zero.
  logic                    zero_all;

  // Subtraction is addition of the inverted operand plus one. The plus one
  // enters through the carry on slice 0 only.
  always_comb begin
    rhs_eff = i_ex_ctl.op == idli_ex_pkg::ALU_SUB ? ~i_ex_rhs : i_ex_rhs;
    cin     = i_ex_ctl.first ? i_ex_ctl.op == idli_ex_pkg::ALU_SUB : carry_q;
    sum     = {1'b0, i_ex_lhs} + {1'b0, rhs_eff} + {{`IDLI_SLICE_W{1'b0}}, cin};
  end

  // Select the result. Logic ops and immediates do not carry.
  always_comb begin
    cout = 1'b0;
    case (i_ex_ctl.op)
      idli_ex_pkg::ALU_ADD,
      idli_ex_pkg::ALU_SUB: begin
        o_ex_out = sum[`IDLI_SLICE_W-1:0];
        cout     = sum[`IDLI_SLICE_W];
      end
      idli_ex_pkg::ALU_AND: o_ex_out = i_ex_lhs & i_ex_rhs;
      idli_ex_pkg::ALU_OR:  o_ex_out = i_ex_lhs | i_ex_rhs;
      idli_ex_pkg::ALU_XOR: o_ex_out = i_ex_lhs ^ i_ex_rhs;
      default:              o_ex_out = i_ex_imm;
    endcase
  end

  // The zero history starts fresh on slice 0.
  always_comb zero_all = (i_ex_ctl.first || zero_q) && o_ex_out == '0;

  // Accumulators move on every slice edge.
  always_ff @(posedge i_ex_gck) begin
    carry_q <= cout;
    zero_q  <= zero_all;
  end

  // Flags describe the whole word and are only produced on slice 3, where
  // the top bit of the word is in the current slice.
  always_comb begin
    o_ex_flags = '0;
    if (&i_ex_ctl.idx) begin
      o_ex_flags.z = zero_all;
      o_ex_flags.n = o_ex_out[`IDLI_SLICE_W-1];
      o_ex_flags.c = cout;
      o_ex_flags.v = (i_ex_lhs[`IDLI_SLICE_W-1] == rhs_eff[`IDLI_SLICE_W-1])
                  && (o_ex_out[`IDLI_SLICE_W-1] != i_ex_lhs[`IDLI_SLICE_W-1]);
    end
  end

endmodule

/* src/idli_ex_cfg.svh */
`ifndef IDLI_EX_CFG_SVH
`define IDLI_EX_CFG_SVH

// Width of a full data word and of each register.
`define IDLI_DATA_W 16

// Width of one slice. Four slices make up a word, so an instruction takes
// four cycles to pass through the stage.
`define IDLI_SLICE_W 4

// Number of general purpose registers. Register 0 always reads as zero.
`define IDLI_NUM_REGS 8

// Width of the conditional execution mask. Bit 0 gives the predicate value
// required for the next instruction to run.
`define IDLI_COND_W 8

`endif

/* src/idli_ex_ctrl.sv */
`timescale 1ns/10ps
`include "idli_ex_cfg.svh"

// Sequencing and processor state for the execute stage.
module idli_ex_ctrl (
  // Clock and reset.
  input  var logic                    i_ex_gck,
  input  var logic                    i_ex_rst_n,

  // Incoming decoded instruction.
  input  var idli_ex_pkg::instr_t     i_ex_instr,
  input  var logic                    i_ex_instr_vld,

  // Operand slices from the register file and results from the ALU.
  input  var idli_ex_pkg::slice_t     i_ex_lhs_slice,
  input  var idli_ex_pkg::slice_t     i_ex_rhs_slice,
  input  var idli_ex_pkg::slice_t     i_ex_alu_out,
  input  var idli_ex_pkg::flags_t     i_ex_alu_flags,

  // Stage status and register file read control.
  output var logic                    o_ex_busy,
  output var idli_ex_pkg::reg_t       o_ex_lhs_reg,
  output var idli_ex_pkg::reg_t       o_ex_rhs_reg,
  output var idli_ex_pkg::slice_idx_t o_ex_idx,

  // ALU control and operands.
  output var idli_ex_pkg::alu_ctl_t   o_ex_alu_ctl,
  output var idli_ex_pkg::slice_t     o_ex_alu_lhs,
  output var idli_ex_pkg::slice_t     o_ex_alu_rhs,
  output var idli_ex_pkg::slice_t     o_ex_alu_imm,

  // Register file write port.
  output var logic                    o_ex_wr_en,
  output var idli_ex_pkg::reg_t       o_ex_wr_reg,
  output var idli_ex_pkg::slice_t     o_ex_wr_slice,

  // Current predicate.
  output var logic                    o_ex_pred
);

  // Sequencing state. The counter names the slice being worked on.
  logic                    busy_q;
  idli_ex_pkg::slice_idx_t idx_q;
  logic                    last;

  // Instruction held for the four cycles it is in the stage.
  idli_ex_pkg::instr_t     instr_q;

  // Predicate and conditional execution mask.
  logic                    pred_q;
  logic                    pred_d;
  idli_ex_pkg::cond_t      cond_q;

  // Decoded properties of the held instruction.
  logic                    skip;
  logic                    is_cmp;
  logic                    is_wr;
  idli_ex_pkg::alu_op_t    alu_op;

  // The final slice is the last busy cycle of an instruction.
  always_comb last = busy_q && &idx_q;

  // Busy rises on accept and falls at the edge that ends slice 3. The
  // counter restarts at zero for every new instruction.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end
    else if (!busy_q) begin
      busy_q <= i_ex_instr_vld;
      idx_q  <= '0;
    end
    else begin
      busy_q <= !last;
      idx_q  <= idx_q + 2'd1;
    end
  end

  // Capture the instruction when it is accepted.
  always_ff @(posedge i_ex_gck) begin
    if (i_ex_instr_vld && !busy_q) begin
      instr_q <= i_ex_instr;
    end
  end

  // The mask only applies when something above bit 0 is set. In that case
  // the instruction runs only if the predicate matches bit 0.
  always_comb skip = |cond_q[`IDLI_COND_W-1:1] && (cond_q[0] != pred_q);

  // Classify the held instruction.
  always_comb begin
    is_cmp = instr_q.op inside {idli_ex_pkg::OP_CMP_EQ, idli_ex_pkg::OP_CMP_LT,
                                idli_ex_pkg::OP_CMP_LTU};
    is_wr  = instr_q.op inside {idli_ex_pkg::OP_ADD, idli_ex_pkg::OP_SUB,
                                idli_ex_pkg::OP_AND, idli_ex_pkg::OP_OR,
                                idli_ex_pkg::OP_XOR, idli_ex_pkg::OP_LDI};
  end

  // Comparisons are subtractions whose result is only used for flags.
  always_comb begin
    case (instr_q.op)
      idli_ex_pkg::OP_ADD: alu_op = idli_ex_pkg::ALU_ADD;
      idli_ex_pkg::OP_AND: alu_op = idli_ex_pkg::ALU_AND;
      idli_ex_pkg::OP_OR:  alu_op = idli_ex_pkg::ALU_OR;
      idli_ex_pkg::OP_XOR: alu_op = idli_ex_pkg::ALU_XOR;
      idli_ex_pkg::OP_SUB,
      idli_ex_pkg::OP_CMP_EQ,
      idli_ex_pkg::OP_CMP_LT,
      idli_ex_pkg::OP_CMP_LTU: alu_op = idli_ex_pkg::ALU_SUB;
      default: alu_op = idli_ex_pkg::ALU_PASS_IMM;
    endcase
  end

  // New predicate value from the whole-word flags of the comparison.
  always_comb begin
    case (instr_q.op)
      idli_ex_pkg::OP_CMP_EQ: pred_d = i_ex_alu_flags.z;
      idli_ex_pkg::OP_CMP_LT: pred_d = i_ex_alu_flags.n ^ i_ex_alu_flags.v;
      default:                pred_d = !i_ex_alu_flags.c;
    endcase
  end

  // Predicate and mask both change at the end of an instruction. A COND
  // that runs loads a fresh mask, anything else consumes one bit of it.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      pred_q <= 1'b0;
      cond_q <= '0;
    end
    else if (last) begin
      if (is_cmp && !skip) begin
        pred_q <= pred_d;
      end
      if (instr_q.op == idli_ex_pkg::OP_COND && !skip) begin
        cond_q <= instr_q.imm[`IDLI_COND_W-1:0];
      end
      else begin
        cond_q <= {1'b0, cond_q[`IDLI_COND_W-1:1]};
      end
    end
  end

  // Register reads follow the held instruction and the slice counter.
  always_comb begin
    o_ex_busy    = busy_q;
    o_ex_lhs_reg = instr_q.lhs;
    o_ex_rhs_reg = instr_q.rhs;
    o_ex_idx     = idx_q;
  end

  // ALU control, operands and the immediate nibble for this slice.
  always_comb begin
    o_ex_alu_ctl.op    = alu_op;
    o_ex_alu_ctl.idx   = idx_q;
    o_ex_alu_ctl.first = idx_q == '0;
    o_ex_alu_lhs       = i_ex_lhs_slice;
    o_ex_alu_rhs       = i_ex_rhs_slice;
    o_ex_alu_imm       = instr_q.imm[`IDLI_SLICE_W*idx_q +: `IDLI_SLICE_W];
  end

  // Writes happen on every busy cycle of a data instruction that runs.
  // Register 0 is never written.
  always_comb begin
    o_ex_wr_en    = busy_q && is_wr && !skip && instr_q.dst != '0;
    o_ex_wr_reg   = instr_q.dst;
    o_ex_wr_slice = i_ex_alu_out;
    o_ex_pred     = pred_q;
  end

endmodule

/* src/idli_ex_pkg.sv */
`include "idli_ex_cfg.svh"

// Types shared by the execute stage.
package idli_ex_pkg;

  // Data word, slice and slice index.
  typedef logic [`IDLI_DATA_W-1:0]  data_t;
  typedef logic [`IDLI_SLICE_W-1:0] slice_t;
  typedef logic [1:0]               slice_idx_t;

  // Register index and conditional execution mask.
  typedef logic [$clog2(`IDLI_NUM_REGS)-1:0] reg_t;
  typedef logic [`IDLI_COND_W-1:0]           cond_t;

  // Decoded instruction opcodes.
  typedef enum logic [3:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LDI,
    OP_CMP_EQ, OP_CMP_LT, OP_CMP_LTU, OP_COND
  } op_t;

  // Operations the slice ALU knows about.
  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_IMM
  } alu_op_t;

  // Instruction as it arrives at the stage.
  typedef struct packed {
    op_t   op;
    reg_t  dst;
    reg_t  lhs;
    reg_t  rhs;
    data_t imm;
  } instr_t;

  // Per-slice control for the ALU. The first bit marks slice 0.
  typedef struct packed {
    alu_op_t    op;
    slice_idx_t idx;
    logic       first;
  } alu_ctl_t;

  // Whole-word flags, produced by the ALU on the last slice.
  typedef struct packed {
    logic z;
    logic n;
    logic c;
    logic v;
  } flags_t;

endpackage

/* src/idli_ex_rf.sv */
`timescale 1ns/10ps
`include "idli_ex_cfg.svh"

// Register file accessed one slice at a time.
module idli_ex_rf (
  // Clock.
  input  var logic                    i_ex_gck,

  // Slice of every register being accessed this cycle.
  input  var idli_ex_pkg::slice_idx_t i_ex_idx,

  // Read ports.
  input  var idli_ex_pkg::reg_t       i_ex_lhs_reg,
  input  var idli_ex_pkg::reg_t       i_ex_rhs_reg,
  output var idli_ex_pkg::slice_t     o_ex_lhs_slice,
  output var idli_ex_pkg::slice_t     o_ex_rhs_slice,

  // Write port.
  input  var logic                    i_ex_wr_en,
  input  var idli_ex_pkg::reg_t       i_ex_wr_reg,
  input  var idli_ex_pkg::slice_t     i_ex_wr_slice
);

  // Register storage, one full word per register.
  idli_ex_pkg::data_t regs_q [`IDLI_NUM_REGS];

  // Bit offset of the current slice inside a word.
  logic [$clog2(`IDLI_DATA_W)-1:0] base;

  always_comb base = {i_ex_idx, 2'b00};

  // Reads are combinational. Register 0 is the zero register and reads as
  // zero whatever its storage holds.
  always_comb begin
    if (i_ex_lhs_reg == '0) begin
      o_ex_lhs_slice = '0;
    end
    else begin
      o_ex_lhs_slice = regs_q[i_ex_lhs_reg][base +: `IDLI_SLICE_W];
    end

    if (i_ex_rhs_reg == '0) begin
      o_ex_rhs_slice = '0;
    end
    else begin
      o_ex_rhs_slice = regs_q[i_ex_rhs_reg][base +: `IDLI_SLICE_W];
    end
  end

  // Only the addressed slice of the destination changes on a write.
  always_ff @(posedge i_ex_gck) begin
    if (i_ex_wr_en) begin
      regs_q[i_ex_wr_reg][base +: `IDLI_SLICE_W] <= i_ex_wr_slice;
    end
  end

endmodule

/* src/idli_ex_top.sv */
`timescale 1ns/10ps

// Nibble-serial execute stage. Each instruction takes four cycles.
module idli_ex_top (
  // Clock and reset.
  input  var logic                i_ex_gck,
  input  var logic                i_ex_rst_n,

  // Instruction input.
  input  var idli_ex_pkg::instr_t i_ex_instr,
  input  var logic                i_ex_instr_vld,
  output var logic                o_ex_busy,

  // Copy of the register file write port.
  output var logic                o_ex_wr_en,
  output var idli_ex_pkg::reg_t   o_ex_wr_reg,
  output var idli_ex_pkg::slice_t o_ex_wr_slice,

  // Predicate.
  output var logic                o_ex_pred
);

  // Register file read control and data.
  idli_ex_pkg::reg_t       lhs_reg;
  idli_ex_pkg::reg_t       rhs_reg;
  idli_ex_pkg::slice_idx_t idx;
  idli_ex_pkg::slice_t     lhs_slice;
  idli_ex_pkg::slice_t     rhs_slice;

  // ALU control, operands and results.
  idli_ex_pkg::alu_ctl_t   alu_ctl;
  idli_ex_pkg::slice_t     alu_lhs;
  idli_ex_pkg::slice_t     alu_rhs;
  idli_ex_pkg::slice_t     alu_imm;
  idli_ex_pkg::slice_t     alu_out;
  idli_ex_pkg::flags_t     alu_flags;

  // Sequencing, predicate and mask.
  idli_ex_ctrl ctrl_u (
    .i_ex_gck, .i_ex_rst_n, .i_ex_instr, .i_ex_instr_vld,
    .i_ex_lhs_slice (lhs_slice),
    .i_ex_rhs_slice (rhs_slice),
    .i_ex_alu_out   (alu_out),
    .i_ex_alu_flags (alu_flags),
    .o_ex_busy,
    .o_ex_lhs_reg   (lhs_reg),
    .o_ex_rhs_reg   (rhs_reg),
    .o_ex_idx       (idx),
    .o_ex_alu_ctl   (alu_ctl),
    .o_ex_alu_lhs   (alu_lhs),
    .o_ex_alu_rhs   (alu_rhs),
    .o_ex_alu_imm   (alu_imm),
    .o_ex_wr_en, .o_ex_wr_reg, .o_ex_wr_slice, .o_ex_pred
  );

  // Register file. Its write port is the one seen at the top level.
  idli_ex_rf rf_u (
    .i_ex_gck,
    .i_ex_idx       (idx),
    .i_ex_lhs_reg   (lhs_reg),
    .i_ex_rhs_reg   (rhs_reg),
    .o_ex_lhs_slice (lhs_slice),
    .o_ex_rhs_slice (rhs_slice),
    .i_ex_wr_en     (o_ex_wr_en),
    .i_ex_wr_reg    (o_ex_wr_reg),
    .i_ex_wr_slice  (o_ex_wr_slice)
  );

  // Slice ALU.
  idli_ex_alu alu_u (
    .i_ex_gck,
    .i_ex_ctl   (alu_ctl),
    .i_ex_lhs   (alu_lhs),
    .i_ex_rhs   (alu_rhs),
    .i_ex_imm   (alu_imm),
    .o_ex_out   (alu_out),
    .o_ex_flags (alu_flags)
  );

endmodule

/* tests/idli_ex_tb.sv */
`timescale 1ns/10ps

// Testbench for the nibble-serial execute stage.
module idli_ex_tb;

  // One table entry with the instruction and the expected results.
  typedef struct packed {
    idli_ex_pkg::instr_t instr;
    logic                exp_wr;
    idli_ex_pkg::data_t  exp_val;
    logic                exp_pred;
  } entry_t;

  logic                gck = 1'b0;
  logic                rst_n;
  idli_ex_pkg::instr_t instr;
  logic                instr_vld;
  logic                busy;
  logic                wr_en;
  idli_ex_pkg::reg_t   wr_reg;
  idli_ex_pkg::slice_t wr_slice;
  logic                pred;

  // Stimulus table and bookkeeping.
  entry_t              stim_q[$];
  int                  errors = 0;
  int                  checks = 0;
  int                  cycles = 0;
  int                  limit = 1000;
  logic [31:0]         lfsr_q = 32'h53f0;

  // Architectural state of the model, used only to fill in expected values.
  idli_ex_pkg::data_t  m_regs [8];
  logic                m_pred = 1'b0;
  idli_ex_pkg::cond_t  m_mask = '0;

  idli_ex_top i_dut (
    .i_ex_gck       (gck),
    .i_ex_rst_n     (rst_n),
    .i_ex_instr     (instr),
    .i_ex_instr_vld (instr_vld),
    .o_ex_busy      (busy),
    .o_ex_wr_en     (wr_en),
    .o_ex_wr_reg    (wr_reg),
    .o_ex_wr_slice  (wr_slice),
    .o_ex_pred      (pred)
  );

  // Free running clock with a 4 ns period.
  always #2 gck = ~gck;

  // Guard against a stuck run. The limit is set once the table is built.
  always @(posedge gck) begin
    cycles++;
    if (cycles >= limit) begin
      $display("ERROR: run did not complete within %0d cycles", limit);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Galois LFSR. One step gives one random bit.
  function automatic logic next_bit();
    lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h80200003 : lfsr_q >> 1;
    return lfsr_q[0];
  endfunction

  function automatic idli_ex_pkg::data_t rand_word();
    idli_ex_pkg::data_t w;
    for (int i = 0; i < 16; i++) w[i] = next_bit();
    return w;
  endfunction

  function automatic idli_ex_pkg::reg_t rand_reg();
    idli_ex_pkg::reg_t r;
    for (int i = 0; i < 3; i++) r[i] = next_bit();
    return r;
  endfunction

  // Adds an instruction and works out what the stage should do with it.
  task automatic add_entry(input idli_ex_pkg::op_t op, input idli_ex_pkg::reg_t dst,
                           input idli_ex_pkg::reg_t lhs, input idli_ex_pkg::reg_t rhs,
                           input idli_ex_pkg::data_t imm);
    entry_t             e;
    logic               skip;
    logic               is_wr;
    idli_ex_pkg::data_t a;
    idli_ex_pkg::data_t b;
    idli_ex_pkg::data_t res;
    a = (lhs == 3'd0) ? 16'h0000 : m_regs[lhs];
    b = (rhs == 3'd0) ? 16'h0000 : m_regs[rhs];
    skip = (m_mask[7:1] != 7'd0) && (m_mask[0] != m_pred);
    is_wr = 1'b1;
    res = '0;
    case (op)
      idli_ex_pkg::OP_ADD: res = a + b;
      idli_ex_pkg::OP_SUB: res = a - b;
      idli_ex_pkg::OP_AND: res = a & b;
      idli_ex_pkg::OP_OR:  res = a | b;
      idli_ex_pkg::OP_XOR: res = a ^ b;
      idli_ex_pkg::OP_LDI: res = imm;
      default:             is_wr = 1'b0;
    endcase
    // A comparison that runs sets the predicate from the whole word.
    if (!skip && op == idli_ex_pkg::OP_CMP_EQ) m_pred = (a == b);
    if (!skip && op == idli_ex_pkg::OP_CMP_LT) m_pred = ($signed(a) < $signed(b));
    if (!skip && op == idli_ex_pkg::OP_CMP_LTU) m_pred = (a < b);
    e.instr.op = op;
    e.instr.dst = dst;
    e.instr.lhs = lhs;
    e.instr.rhs = rhs;
    e.instr.imm = imm;
    e.exp_wr = is_wr && !skip && dst != 3'd0;
    e.exp_val = res;
    if (e.exp_wr) m_regs[dst] = res;
    // The mask is reloaded by a COND that runs and shifted by anything else.
    if (!skip && op == idli_ex_pkg::OP_COND) m_mask = imm[7:0];
    else m_mask = {1'b0, m_mask[7:1]};
    e.exp_pred = m_pred;
    stim_q.push_back(e);
  endtask

  task automatic check_word(input string name, input idli_ex_pkg::data_t got,
                            input idli_ex_pkg::data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_reg(input string name, input idli_ex_pkg::reg_t got,
                           input idli_ex_pkg::reg_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_pred(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch o_ex_pred: got %h, expected %h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_busy(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch o_ex_busy: got %h, expected %h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_wr_en(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch o_ex_wr_en: got %h, expected %h at %0t", got, exp, $time);
    end
  endtask

  // Builds the whole table before the clock starts to matter.
  task automatic build_table();
    m_regs[0] = '0;
    for (int r = 1; r < 8; r++) add_entry(idli_ex_pkg::OP_LDI, r[2:0], 3'd0, 3'd0, rand_word());
    // Each ALU operation on random registers.
    for (int o = 0; o < 5; o++) begin
      repeat (3) add_entry(idli_ex_pkg::op_t'(o[3:0]), rand_reg(), rand_reg(), rand_reg(), '0);
    end
    // Signed and unsigned order disagree on these two values.
    add_entry(idli_ex_pkg::OP_LDI, 3'd6, 3'd0, 3'd0, 16'h8000);
    add_entry(idli_ex_pkg::OP_LDI, 3'd7, 3'd0, 3'd0, 16'h0001);
    add_entry(idli_ex_pkg::OP_CMP_LT, 3'd1, 3'd6, 3'd7, '0);
    add_entry(idli_ex_pkg::OP_CMP_LTU, 3'd1, 3'd6, 3'd7, '0);
    add_entry(idli_ex_pkg::OP_CMP_EQ, 3'd0, 3'd6, 3'd6, '0);
    add_entry(idli_ex_pkg::OP_CMP_EQ, 3'd2, 3'd6, 3'd7, '0);
    add_entry(idli_ex_pkg::OP_CMP_LTU, 3'd0, 3'd7, 3'd6, '0);
    // Conditional block with a mixed mask and a predicate change inside it.
    add_entry(idli_ex_pkg::OP_CMP_EQ, 3'd0, 3'd1, 3'd1, '0);
    add_entry(idli_ex_pkg::OP_COND, 3'd0, 3'd0, 3'd0, 16'h00bd);
    add_entry(idli_ex_pkg::OP_ADD, 3'd2, 3'd1, 3'd3, '0);
    add_entry(idli_ex_pkg::OP_SUB, 3'd3, 3'd2, 3'd4, '0);
    add_entry(idli_ex_pkg::OP_LDI, 3'd4, 3'd0, 3'd0, rand_word());
    add_entry(idli_ex_pkg::OP_CMP_EQ, 3'd0, 3'd6, 3'd7, '0);
    add_entry(idli_ex_pkg::OP_XOR, 3'd5, 3'd4, 3'd2, '0);
    add_entry(idli_ex_pkg::OP_OR, 3'd1, 3'd5, 3'd3, '0);
    add_entry(idli_ex_pkg::OP_AND, 3'd2, 3'd1, 3'd4, '0);
    add_entry(idli_ex_pkg::OP_LDI, 3'd3, 3'd0, 3'd0, rand_word());
    add_entry(idli_ex_pkg::OP_ADD, 3'd4, 3'd3, 3'd3, '0);
    // Register 0 as a destination and as a source.
    add_entry(idli_ex_pkg::OP_LDI, 3'd0, 3'd0, 3'd0, 16'h1234);
    add_entry(idli_ex_pkg::OP_ADD, 3'd0, 3'd1, 3'd2, '0);
    add_entry(idli_ex_pkg::OP_ADD, 3'd3, 3'd0, 3'd4, '0);
    add_entry(idli_ex_pkg::OP_OR, 3'd5, 3'd0, 3'd0, '0);
    // Random mix of data operations and comparisons.
    repeat (16) begin
      add_entry(idli_ex_pkg::op_t'({1'b0, next_bit(), next_bit(), next_bit()}),
                rand_reg(), rand_reg(), rand_reg(), rand_word());
    end
  endtask

  initial begin
    entry_t             e;
    idli_ex_pkg::data_t word;
    rst_n = 1'b0;
    instr = '0;
    instr_vld = 1'b0;
    build_table();
    limit = 5 * stim_q.size() + 10 + 50;
    repeat (10) @(posedge gck);
    #1 rst_n = 1'b1;
    check_busy(busy, 1'b0);
    check_wr_en(wr_en, 1'b0);
    check_pred(pred, 1'b0);
    // Each pass starts 1 ns after a rising edge with the stage idle.
    foreach (stim_q[i]) begin
      e = stim_q[i];
      word = '0;
      instr = e.instr;
      instr_vld = 1'b1;
      @(posedge gck);
      #1 instr_vld = 1'b0;
      for (int k = 0; k < 4; k++) begin
        @(negedge gck);
        check_busy(busy, 1'b1);
        check_wr_en(wr_en, e.exp_wr);
        if (wr_en) begin
          check_reg("o_ex_wr_reg", wr_reg, e.instr.dst);
          word[4*k +: 4] = wr_slice;
        end
      end
      if (e.exp_wr) check_word("o_ex_wr_slice", word, e.exp_val);
      @(posedge gck);
      #1;
      check_busy(busy, 1'b0);
      check_pred(pred, e.exp_pred);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end
    else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
